// File: all.f
common/mbox_pkg.sv
rtl/fifo/fifo_sync_cnt.sv
rtl/fifo/fifo_sync.sv
rtl/mbox_len_tracker.sv
rtl/mbox_regs.sv
rtl/mbox_top.sv
verif/tb_mbox.sv

// File: Makefile
# Verilator build and run for the mailbox testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_mbox
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Testbench passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# pass only when the pass line shows up in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_mbox.sv
/*
 * mailbox testbench
 * random producer and consumer traffic against a queue model,
 * register status, clear and error flag checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mbox;

  localparam int unsigned DataDepth = 8;
  localparam int unsigned LenDepth  = 4;
  localparam bit          Pass      = 1'b0;
  localparam int unsigned Timeout   = 1000;
  localparam logic [31:0] Seed      = 32'h6349_9bb2;

  // consumer behaviour
  localparam int ConsReady  = 0;
  localparam int ConsRandom = 1;
  localparam int ConsHold   = 2;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            wvalid_i;
  logic                            wready_o;
  mbox_pkg::word_t                 wdata_i;
  logic                            wlast_i;
  logic                            rvalid_o;
  logic                            rready_i;
  mbox_pkg::word_t                 rdata_o;
  logic                            len_valid_o;
  logic                            len_ready_i;
  mbox_pkg::len_t                  len_o;
  logic                            reg_we_i;
  logic [mbox_pkg::REG_ADDR_W-1:0] reg_addr_i;
  logic [mbox_pkg::REG_DATA_W-1:0] reg_wdata_i;
  logic [mbox_pkg::REG_DATA_W-1:0] reg_rdata_o;

  // model state, owned by the monitor
  mbox_pkg::word_t exp_words[$];
  mbox_pkg::len_t  exp_lens[$];
  int unsigned     msg_words;
  int unsigned     flush_seen;
  // stimulus state, owned by the main flow
  int unsigned     flush_req;
  int              cons_mode;
  logic [31:0]     prod_rng;
  logic [31:0]     cons_rng;
  logic [31:0]     rd_val;

  mbox_top #(
    .DataDepth(DataDepth),
    .LenDepth (LenDepth),
    .Pass     (Pass)
  ) dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wvalid_i   (wvalid_i),
    .wready_o   (wready_o),
    .wdata_i    (wdata_i),
    .wlast_i    (wlast_i),
    .rvalid_o   (rvalid_o),
    .rready_i   (rready_i),
    .rdata_o    (rdata_o),
    .len_valid_o(len_valid_o),
    .len_ready_i(len_ready_i),
    .len_o      (len_o),
    .reg_we_i   (reg_we_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o)
  );

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // words up to and including the last flag, saturating
  function automatic mbox_pkg::len_t ref_len(input int unsigned words);
    int unsigned max_len;
    max_len = (1 << mbox_pkg::LEN_W) - 1;
    if (words > max_len) begin
      words = max_len;
    end
    return mbox_pkg::len_t'(words);
  endfunction

  // expected status register contents
  function automatic logic [31:0] status_word(input int unsigned data_depth,
                                              input int unsigned len_depth,
                                              input logic data_full,
                                              input logic len_full);
    logic [31:0] word;
    word = '0;
    word[mbox_pkg::STAT_DATA_DEPTH_LSB +: 8] = 8'(data_depth);
    word[mbox_pkg::STAT_LEN_DEPTH_LSB +: 8]  = 8'(len_depth);
    word[mbox_pkg::STAT_DATA_FULL_BIT]       = data_full;
    word[mbox_pkg::STAT_LEN_FULL_BIT]        = len_full;
    return word;
  endfunction

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected 0x%h, actual 0x%h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic idle_cycles(input int unsigned count);
    repeat (count) @(negedge clk_i);
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_word(input mbox_pkg::word_t data, input logic last);
    int unsigned waited;
    waited   = 0;
    wvalid_i = 1'b1;
    wdata_i  = data;
    wlast_i  = last;
    @(posedge clk_i);
    while (!wready_o) begin
      waited++;
      if (waited > Timeout) begin
        $display("Timeout: producer word was never accepted");
        abort_run();
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    wvalid_i = 1'b0;
    wlast_i  = 1'b0;
  endtask

  task automatic send_random_messages(input int unsigned count);
    int unsigned words;
    int unsigned gap;
    for (int unsigned m = 0; m < count; m++) begin
      prod_rng = lcg_next(prod_rng);
      words    = (prod_rng >> 24) % 6 + 1;
      for (int unsigned i = 0; i < words; i++) begin
        // producer gap on about half the words
        prod_rng = lcg_next(prod_rng);
        gap      = prod_rng[31] ? 0 : ((prod_rng >> 28) & 3);
        idle_cycles(gap);
        prod_rng = lcg_next(prod_rng);
        send_word(prod_rng, i == words - 1);
      end
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    reg_we_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(negedge clk_i);
    reg_we_i    = 1'b0;
    reg_wdata_i = '0;
  endtask

  // read data is combinational on the address
  task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
    reg_addr_i = addr;
    @(posedge clk_i);
    data = reg_rdata_o;
    @(negedge clk_i);
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (exp_words.size() != 0 || exp_lens.size() != 0) begin
      waited++;
      if (waited > Timeout) begin
        $display("Timeout: consumer did not receive all expected words and lengths");
        abort_run();
      end
      @(negedge clk_i);
    end
  endtask

  task automatic check_err_zero(input string name);
    read_reg(mbox_pkg::REG_ERR, rd_val);
    compare_value(name, 32'd0, rd_val);
  endtask

  ////////////////////////////////////////////////////////////
  // clock, consumer and monitor
  ////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // consumer ready pattern, changed on the falling edge
  initial begin
    rready_i    = 1'b0;
    len_ready_i = 1'b0;
    cons_rng    = Seed ^ 32'h5a5a_a5a5;
    forever begin
      @(negedge clk_i);
      cons_rng = lcg_next(cons_rng);
      case (cons_mode)
        ConsReady: begin
          rready_i    = 1'b1;
          len_ready_i = 1'b1;
        end
        ConsRandom: begin
          rready_i    = (cons_rng[31:30] != 2'b00);
          len_ready_i = (cons_rng[29:28] != 2'b00);
        end
        default: begin
          rready_i    = 1'b0;
          len_ready_i = 1'b0;
        end
      endcase
    end
  end

  // records accepted words, then compares every consumer transfer
  initial begin
    msg_words  = 0;
    flush_seen = 0;
    forever begin
      @(posedge clk_i);
      // model follows a register clear
      if (flush_req != flush_seen) begin
        exp_words.delete();
        exp_lens.delete();
        msg_words  = 0;
        flush_seen = flush_req;
      end
      if (rst_ni && wvalid_i && wready_o) begin
        exp_words.push_back(wdata_i);
        msg_words++;
        if (wlast_i) begin
          exp_lens.push_back(ref_len(msg_words));
          msg_words = 0;
        end
      end
      if (rst_ni && rvalid_o && rready_i) begin
        if (exp_words.size() == 0) begin
          $display("Error: DUT delivered a word that was never accepted");
          abort_run();
        end
        compare_value("data_word", exp_words.pop_front(), rdata_o);
      end
      if (rst_ni && len_valid_o && len_ready_i) begin
        if (exp_lens.size() == 0) begin
          $display("Error: DUT delivered a length with no closed message");
          abort_run();
        end
        compare_value("msg_len", 32'(exp_lens.pop_front()), 32'(len_o));
      end
    end
  end

  // overall limit
  initial begin
    repeat (Timeout * 200) @(posedge clk_i);
    $display("Timeout: simulation ran past its cycle limit");
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    wvalid_i    = 1'b0;
    wdata_i     = '0;
    wlast_i     = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    cons_mode   = ConsReady;
    flush_req   = 0;
    prod_rng    = Seed;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;

    // reset: FIFO still held off for one cycle
    @(posedge clk_i);
    compare_value("reset_wready_hold", 32'd0, 32'(wready_o));
    compare_value("reset_rvalid", 32'd0, 32'(rvalid_o));
    compare_value("reset_len_valid", 32'd0, 32'(len_valid_o));
    @(negedge clk_i);
    compare_value("reset_wready", 32'd1, 32'(wready_o));
    compare_value("reset_rvalid_idle", 32'd0, 32'(rvalid_o));
    compare_value("reset_len_valid_idle", 32'd0, 32'(len_valid_o));
    read_reg(mbox_pkg::REG_STATUS, rd_val);
    compare_value("reset_status", status_word(0, 0, 1'b0, 1'b0), rd_val);
    check_err_zero("reset_err");

    // single three word message
    send_word(32'h1111_0001, 1'b0);
    send_word(32'h2222_0002, 1'b0);
    send_word(32'h3333_0003, 1'b1);
    wait_drained();
    check_err_zero("single_err");

    // random traffic with stalls on both sides
    cons_mode = ConsRandom;
    send_random_messages(100);
    wait_drained();
    check_err_zero("random_err");

    // fill the data FIFO with the consumer held off
    cons_mode = ConsHold;
    idle_cycles(2);
    for (int unsigned i = 0; i < DataDepth; i++) begin
      send_word(32'hc0de_0000 + i, i == DataDepth - 1);
    end
    wvalid_i = 1'b1;
    wdata_i  = 32'hdead_beef;
    wlast_i  = 1'b0;
    repeat (4) begin
      @(posedge clk_i);
      compare_value("full_wready", 32'd0, 32'(wready_o));
    end
    @(negedge clk_i);
    wvalid_i = 1'b0;
    read_reg(mbox_pkg::REG_STATUS, rd_val);
    compare_value("full_status", status_word(DataDepth, 1, 1'b1, 1'b0), rd_val);
    cons_mode = ConsReady;
    wait_drained();
    check_err_zero("full_err");

    // clear with a closed and an open message held
    cons_mode = ConsHold;
    idle_cycles(2);
    send_word(32'h5555_0001, 1'b0);
    send_word(32'h5555_0002, 1'b0);
    send_word(32'h5555_0003, 1'b1);
    send_word(32'h6666_0001, 1'b0);
    send_word(32'h6666_0002, 1'b0);
    read_reg(mbox_pkg::REG_STATUS, rd_val);
    compare_value("held_status", status_word(5, 1, 1'b0, 1'b0), rd_val);
    write_reg(mbox_pkg::REG_CTRL, 32'h1);
    // clear pulse is active in this cycle
    compare_value("clear_rvalid", 32'd0, 32'(rvalid_o));
    compare_value("clear_len_valid", 32'd0, 32'(len_valid_o));
    flush_req++;
    @(negedge clk_i);
    compare_value("cleared_rvalid", 32'd0, 32'(rvalid_o));
    compare_value("cleared_len_valid", 32'd0, 32'(len_valid_o));
    read_reg(mbox_pkg::REG_STATUS, rd_val);
    compare_value("cleared_status", status_word(0, 0, 1'b0, 1'b0), rd_val);
    cons_mode = ConsRandom;
    send_random_messages(20);
    wait_drained();
    check_err_zero("clear_err");

    // write one to the error flag
    write_reg(mbox_pkg::REG_ERR, 32'h1);
    check_err_zero("err_w1c");

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/mbox_top.sv
/*
 * message mailbox top level
 * data FIFO, length FIFO, length tracker and register block
 */
`timescale 1ns/1ps
`default_nettype none

module mbox_top #(
  parameter int unsigned DataDepth = 8,
  parameter int unsigned LenDepth  = 4,
  parameter bit          Pass      = 1'b0
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // producer
  input  logic                            wvalid_i,
  output logic                            wready_o,
  input  mbox_pkg::word_t                 wdata_i,
  input  logic                            wlast_i,
  // consumer, words
  output logic                            rvalid_o,
  input  logic                            rready_i,
  output mbox_pkg::word_t                 rdata_o,
  // consumer, lengths
  output logic                            len_valid_o,
  input  logic                            len_ready_i,
  output mbox_pkg::len_t                  len_o,
  // register port
  input  logic                            reg_we_i,
  input  logic [mbox_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [mbox_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [mbox_pkg::REG_DATA_W-1:0] reg_rdata_o
);

  localparam int unsigned DataDepthW = $clog2(DataDepth + 1);
  localparam int unsigned LenDepthW  = $clog2(LenDepth + 1);

  logic                  clr;
  logic                  data_ready;
  logic                  data_push;
  logic                  data_full;
  logic [DataDepthW-1:0] data_depth;
  logic                  data_err;
  logic                  len_ready;
  logic                  len_push;
  mbox_pkg::len_t        len_wdata;
  logic                  len_full;
  logic [LenDepthW-1:0]  len_depth;
  logic                  len_err;

  // word enters the data fifo only on a full producer handshake
  assign data_push = wvalid_i & wready_o;

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  fifo_sync #(
    .T    (mbox_pkg::word_t),
    .Depth(DataDepth),
    .Pass (Pass)
  ) u_data_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clr_i   (clr),
    .wvalid_i(data_push),
    .wready_o(data_ready),
    .wdata_i (wdata_i),
    .rvalid_o(rvalid_o),
    .rready_i(rready_i),
    .rdata_o (rdata_o),
    .full_o  (data_full),
    .depth_o (data_depth),
    .err_o   (data_err)
  );

  // one length per closed message
  fifo_sync #(
    .T    (mbox_pkg::len_t),
    .Depth(LenDepth),
    .Pass (Pass)
  ) u_len_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clr_i   (clr),
    .wvalid_i(len_push),
    .wready_o(len_ready),
    .wdata_i (len_wdata),
    .rvalid_o(len_valid_o),
    .rready_i(len_ready_i),
    .rdata_o (len_o),
    .full_o  (len_full),
    .depth_o (len_depth),
    .err_o   (len_err)
  );

  mbox_len_tracker u_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clr_i       (clr),
    .wvalid_i    (wvalid_i),
    .wlast_i     (wlast_i),
    .data_ready_i(data_ready),
    .len_ready_i (len_ready),
    .wready_o    (wready_o),
    .len_push_o  (len_push),
    .len_o       (len_wdata)
  );

  ////////////////////////////////////////////////////////////
  // control and status
  ////////////////////////////////////////////////////////////

  mbox_regs #(
    .DataDepth(DataDepth),
    .LenDepth (LenDepth)
  ) u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .data_depth_i(data_depth),
    .len_depth_i (len_depth),
    .data_full_i (data_full),
    .len_full_i  (len_full),
    .data_err_i  (data_err),
    .len_err_i   (len_err),
    .clr_o       (clr)
  );

endmodule

`default_nettype wire

// File: rtl/mbox_regs.sv
/*
 * mailbox register block
 * clear pulse, occupancy status and sticky pointer error
 */
`timescale 1ns/1ps
`default_nettype none

module mbox_regs #(
  parameter int unsigned  DataDepth  = 8,
  parameter int unsigned  LenDepth   = 4,
  localparam int unsigned DataDepthW = $clog2(DataDepth + 1),
  localparam int unsigned LenDepthW  = $clog2(LenDepth + 1)
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // write strobe port
  input  logic                            reg_we_i,
  input  logic [mbox_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [mbox_pkg::REG_DATA_W-1:0] reg_wdata_i,
  output logic [mbox_pkg::REG_DATA_W-1:0] reg_rdata_o,
  // datapath status
  input  logic [DataDepthW-1:0]           data_depth_i,
  input  logic [LenDepthW-1:0]            len_depth_i,
  input  logic                            data_full_i,
  input  logic                            len_full_i,
  input  logic                            data_err_i,
  input  logic                            len_err_i,
  // flush to fifos and tracker
  output logic                            clr_o
);

  logic ctrl_wr;
  logic err_wr;
  logic clr_q;
  logic err_q;

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  assign ctrl_wr = reg_we_i & (reg_addr_i == mbox_pkg::REG_CTRL);
  assign err_wr  = reg_we_i & (reg_addr_i == mbox_pkg::REG_ERR);

  // one-cycle clear, the cycle after the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_q <= 1'b0;
    end else begin
      clr_q <= ctrl_wr & reg_wdata_i[mbox_pkg::CTRL_CLR_BIT];
    end
  end

  assign clr_o = clr_q;

  // sticky error, a new error wins over write-one-to-clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if (data_err_i || len_err_i) begin
      err_q <= 1'b1;
    end else if (err_wr && reg_wdata_i[mbox_pkg::ERR_BIT]) begin
      err_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    reg_rdata_o = '0;
    case (reg_addr_i)
      mbox_pkg::REG_STATUS: begin
        reg_rdata_o[mbox_pkg::STAT_DATA_DEPTH_LSB +: DataDepthW] = data_depth_i;
        reg_rdata_o[mbox_pkg::STAT_LEN_DEPTH_LSB +: LenDepthW]   = len_depth_i;
        reg_rdata_o[mbox_pkg::STAT_DATA_FULL_BIT]                = data_full_i;
        reg_rdata_o[mbox_pkg::STAT_LEN_FULL_BIT]                 = len_full_i;
      end
      mbox_pkg::REG_ERR: begin
        reg_rdata_o[mbox_pkg::ERR_BIT] = err_q;
      end
      // ctrl is a pulse, reads as zero
      default: begin
        reg_rdata_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/mbox_len_tracker.sv
/*
 * message length tracker
 * counts accepted words and pushes the length on the last one
 */
`timescale 1ns/1ps
`default_nettype none

module mbox_len_tracker (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            clr_i,
  input  logic            wvalid_i,
  input  logic            wlast_i,
  input  logic            data_ready_i,
  input  logic            len_ready_i,
  output logic            wready_o,
  output logic            len_push_o,
  output mbox_pkg::len_t  len_o
);

  mbox_pkg::len_t cnt_q;
  logic           accept;

  // last word also needs room for its length
  assign wready_o   = data_ready_i & (~wlast_i | len_ready_i);
  assign accept     = wvalid_i & wready_o;
  assign len_push_o = accept & wlast_i;

  // count plus the closing word, saturating
  assign len_o = (&cnt_q) ? cnt_q : cnt_q + mbox_pkg::LEN_W'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (accept) begin
      // restart after the closing word
      if (wlast_i) begin
        cnt_q <= '0;
      end else if (!(&cnt_q)) begin
        cnt_q <= cnt_q + mbox_pkg::LEN_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/fifo/fifo_sync.sv
/*
 * generic synchronous FIFO
 * wrap-bit pointers, optional pass-through when empty,
 * synchronous clear, occupancy and pointer error outputs
 */
`timescale 1ns/1ps
`default_nettype none

module fifo_sync #(
  parameter type          T      = logic [7:0],
  parameter int unsigned  Depth  = 4,
  parameter bit           Pass   = 1'b0,
  localparam int unsigned DepthW = $clog2(Depth + 1)
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // synchronous flush
  input  logic              clr_i,
  // write side
  input  logic              wvalid_i,
  output logic              wready_o,
  input  T                  wdata_i,
  // read side
  output logic              rvalid_o,
  input  logic              rready_i,
  output T                  rdata_o,
  // occupancy
  output logic              full_o,
  output logic [DepthW-1:0] depth_o,
  output logic              err_o
);

  // wrap bit sits above the pointer value bits
  localparam int unsigned PtrW = $clog2(Depth);

  logic [PtrW:0]   wptr;
  logic [PtrW:0]   rptr;
  logic [PtrW-1:0] wptr_val;
  logic [PtrW-1:0] rptr_val;
  logic            wptr_wrap;
  logic            rptr_wrap;
  logic            incr_wptr;
  logic            incr_rptr;
  logic            under_rst;
  logic            full;
  logic            fifo_empty;
  logic            empty;
  T                storage [Depth];
  T                storage_rdata;

  ////////////////////////////////////////////////////////////
  // reset hold-off
  ////////////////////////////////////////////////////////////

  // high for the first cycle after reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      under_rst <= 1'b1;
    end else begin
      under_rst <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers and flags
  ////////////////////////////////////////////////////////////

  fifo_sync_cnt #(
    .Depth(Depth)
  ) u_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clr_i      (clr_i),
    .incr_wptr_i(incr_wptr),
    .incr_rptr_i(incr_rptr),
    .wptr_o     (wptr),
    .rptr_o     (rptr),
    .err_o      (err_o)
  );

  assign wptr_wrap = wptr[PtrW];
  assign rptr_wrap = rptr[PtrW];
  assign wptr_val  = wptr[PtrW-1:0];
  assign rptr_val  = rptr[PtrW-1:0];

  // full when values match and wrap bits differ
  assign full       = (wptr == (rptr ^ {1'b1, {PtrW{1'b0}}}));
  assign fifo_empty = (wptr == rptr);

  // no transfers while held off or flushing
  assign wready_o  = ~full & ~under_rst & ~clr_i;
  assign rvalid_o  = ~empty & ~under_rst & ~clr_i;
  assign incr_wptr = wvalid_i & wready_o;
  assign incr_rptr = rvalid_o & rready_i;

  assign full_o = full;

  // occupancy from pointer distance
  // full lands in the lap case and yields Depth
  assign depth_o = (wptr_wrap == rptr_wrap) ? DepthW'(wptr_val) - DepthW'(rptr_val) :
                   DepthW'(Depth) - DepthW'(rptr_val) + DepthW'(wptr_val);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (incr_wptr) begin
      storage[wptr_val] <= wdata_i;
    end
  end

  assign storage_rdata = storage[rptr_val];

  // empty fifo forwards the incoming word
  if (Pass) begin : gen_pass
    assign empty   = fifo_empty & ~wvalid_i;
    assign rdata_o = fifo_empty ? wdata_i : storage_rdata;
  end else begin : gen_no_pass
    assign empty   = fifo_empty;
    assign rdata_o = storage_rdata;
  end

endmodule

`default_nettype wire

// File: rtl/fifo/fifo_sync_cnt.sv
/*
 * FIFO pointer pair
 * read and write pointers with wrap bit, plus a consistency check
 */
`timescale 1ns/1ps
`default_nettype none

module fifo_sync_cnt #(
  parameter int unsigned  Depth = 4,
  localparam int unsigned PtrW  = $clog2(Depth)
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clr_i,
  input  logic          incr_wptr_i,
  input  logic          incr_rptr_i,
  output logic [PtrW:0] wptr_o,
  output logic [PtrW:0] rptr_o,
  output logic          err_o
);

  logic [PtrW:0] wptr_q;
  logic [PtrW:0] rptr_q;
  logic          val_err;
  logic          dist_err;

  // step one entry, wrap at Depth and flip the wrap bit
  function automatic logic [PtrW:0] next_ptr(input logic [PtrW:0] ptr);
    logic [PtrW:0] nxt;
    if (ptr[PtrW-1:0] == PtrW'(Depth - 1)) begin
      nxt = {~ptr[PtrW], {PtrW{1'b0}}};
    end else begin
      nxt = ptr + (PtrW + 1)'(1);
    end
    return nxt;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
    end else if (incr_wptr_i) begin
      wptr_q <= next_ptr(wptr_q);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q <= '0;
    end else if (clr_i) begin
      rptr_q <= '0;
    end else if (incr_rptr_i) begin
      rptr_q <= next_ptr(rptr_q);
    end
  end

  assign wptr_o = wptr_q;
  assign rptr_o = rptr_q;

  // value outside the storage range
  assign val_err = ({1'b0, wptr_q[PtrW-1:0]} >= (PtrW + 1)'(Depth)) |
                   ({1'b0, rptr_q[PtrW-1:0]} >= (PtrW + 1)'(Depth));

  // same lap: writer behind reader
  // next lap: writer past reader, more than Depth apart
  assign dist_err = (wptr_q[PtrW] == rptr_q[PtrW]) ?
                    (wptr_q[PtrW-1:0] < rptr_q[PtrW-1:0]) :
                    (wptr_q[PtrW-1:0] > rptr_q[PtrW-1:0]);

  assign err_o = val_err | dist_err;

endmodule

`default_nettype wire

// File: common/mbox_pkg.sv
/*
 * mbox shared definitions
 * word and length payloads, register map and status field layout
 */
`default_nettype none

package mbox_pkg;

  ////////////////////////////////////////////////////////////
  // payloads
  ////////////////////////////////////////////////////////////

  // one message word
  localparam int unsigned DATA_W = 32;
  typedef logic [DATA_W-1:0] word_t;

  // message length in words, saturates at all ones
  localparam int unsigned LEN_W = 8;
  typedef logic [LEN_W-1:0] len_t;

  ////////////////////////////////////////////////////////////
  // register port
  ////////////////////////////////////////////////////////////

  localparam int unsigned REG_ADDR_W = 2;
  localparam int unsigned REG_DATA_W = 32;

  // register map
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = REG_ADDR_W'(0);
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = REG_ADDR_W'(1);
  localparam logic [REG_ADDR_W-1:0] REG_ERR    = REG_ADDR_W'(2);

  // ctrl and err bit positions
  localparam int unsigned CTRL_CLR_BIT = 0;
  localparam int unsigned ERR_BIT      = 0;

  // status layout, depth fields are 8 bits wide
  localparam int unsigned STAT_DATA_DEPTH_LSB = 0;
  localparam int unsigned STAT_LEN_DEPTH_LSB  = 8;
  localparam int unsigned STAT_DATA_FULL_BIT  = 16;
  localparam int unsigned STAT_LEN_FULL_BIT   = 17;

endpackage

`default_nettype wire
